//--- logic/iob_bus_pkg.sv
package iob_bus_pkg;

   // Native bus shape seen by the master and every follower

   // Byte address width
   localparam int ADDR_W = 32;

   // Read and write data width
   localparam int DATA_W = 32;

   // One write strobe per data byte
   localparam int STRB_W = DATA_W / 8;

   // Followers behind the splitter

   // SRAM and GPIO register block
   localparam int N_FOLLOWERS = 2;

   // Index width of the follower selection
   localparam int SEL_W = $clog2(N_FOLLOWERS);

   // Byte lane width, used when walking the strobes
   localparam int BYTE_W = 8;

endpackage

//--- logic/iob_gpio_regs.sv
module iob_gpio_regs (
   input  logic                             clk_i,
   input  logic                             rst_n_i,

   input  logic                             avalid_i,
   input  logic [iob_bus_pkg::ADDR_W-1:0]   addr_i,
   input  logic [iob_bus_pkg::DATA_W-1:0]   wdata_i,
   input  logic [iob_bus_pkg::STRB_W-1:0]   wstrb_i,
   output logic [iob_bus_pkg::DATA_W-1:0]   rdata_o,
   output logic                             rvalid_o,
   output logic                             ready_o,

   // GPIO pins
   input  logic [iob_bus_pkg::DATA_W-1:0]   gpio_i,
   output logic [iob_bus_pkg::DATA_W-1:0]   gpio_o
);

   import iob_bus_pkg::*;
   import iob_map_pkg::*;

   bus_addr_u         addr_u;
   logic              acc;
   logic              is_wr;
   logic              wr_scratch;
   logic              wr_gpio_out;
   logic [DATA_W-1:0] rd_word;

   logic [DATA_W-1:0] scratch_q;
   logic [DATA_W-1:0] gpio_out_q;
   logic [DATA_W-1:0] gpio_in_q;
   logic [DATA_W-1:0] rdata_q;
   logic              rvalid_q;
   logic              ready_q;

   assign addr_u.raw = addr_i;

   assign ready_o = ready_q;
   assign acc     = avalid_i && ready_o;
   assign is_wr   = |wstrb_i;

   // Unmapped offsets fall through both enables
   assign wr_scratch  = acc && is_wr && (addr_u.fields.offset == REG_SCRATCH);
   assign wr_gpio_out = acc && is_wr && (addr_u.fields.offset == REG_GPIO_OUT);

   // Read decode
   always_comb begin
      case (addr_u.fields.offset)
         REG_SCRATCH:  rd_word = scratch_q;
         REG_GPIO_OUT: rd_word = gpio_out_q;
         REG_GPIO_IN:  rd_word = gpio_in_q;
         default:      rd_word = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         scratch_q  <= '0;
         gpio_out_q <= '0;
         gpio_in_q  <= '0;
         rvalid_q   <= 1'b0;
         ready_q    <= 1'b1;
      end else begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wr_scratch && wstrb_i[b]) begin
               scratch_q[b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
            end
            if (wr_gpio_out && wstrb_i[b]) begin
               gpio_out_q[b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
            end
         end
         // Input pins sampled every cycle
         gpio_in_q <= gpio_i;
         rvalid_q  <= acc;
         // One settle cycle for the pins after any write
         ready_q   <= !(acc && is_wr);
      end
   end

   always_ff @(posedge clk_i) begin
      if (acc) begin
         rdata_q <= is_wr ? '0 : rd_word;
      end
   end

   assign rdata_o  = rdata_q;
   assign rvalid_o = rvalid_q;
   assign gpio_o   = gpio_out_q;

   // A write is answered next cycle and blocks acceptance in that cycle
   a_wr_settle: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (acc && is_wr) |=> (rvalid_o && !(avalid_i && ready_o))
   ) else $error("gpio: request accepted during the settle cycle");

endmodule

//--- logic/iob_map_pkg.sv
package iob_map_pkg;

   // Address split: region in the top bits, byte offset below
   localparam int REGION_W = 4;
   localparam int OFFSET_W = iob_bus_pkg::ADDR_W - REGION_W;

   // Region numbers, one per follower
   localparam int REGION_SRAM = 0;
   localparam int REGION_GPIO = 1;

   // SRAM depth in words; word index is offset bits 7..2
   localparam int SRAM_WORDS = 64;

   // GPIO register block byte offsets
   localparam logic [OFFSET_W-1:0] REG_SCRATCH  = OFFSET_W'('h0);
   localparam logic [OFFSET_W-1:0] REG_GPIO_OUT = OFFSET_W'('h4);
   localparam logic [OFFSET_W-1:0] REG_GPIO_IN  = OFFSET_W'('h8);

   // One address word, read raw or as region and offset
   typedef union packed {
      logic [iob_bus_pkg::ADDR_W-1:0] raw;
      struct packed {
         logic [REGION_W-1:0] region;
         logic [OFFSET_W-1:0] offset;
      } fields;
   } bus_addr_u;

endpackage

//--- logic/iob_split.sv
module iob_split (
   input  logic                                                clk_i,
   input  logic                                                rst_n_i,

   // Master side
   input  logic                                                m_avalid_i,
   input  logic [iob_bus_pkg::ADDR_W-1:0]                      m_addr_i,
   input  logic [iob_bus_pkg::DATA_W-1:0]                      m_wdata_i,
   input  logic [iob_bus_pkg::STRB_W-1:0]                      m_wstrb_i,
   output logic [iob_bus_pkg::DATA_W-1:0]                      m_rdata_o,
   output logic                                                m_rvalid_o,
   output logic                                                m_ready_o,

   // Follower side, one slice per follower
   output logic [iob_bus_pkg::N_FOLLOWERS-1:0]                 f_avalid_o,
   output logic [iob_bus_pkg::N_FOLLOWERS*iob_bus_pkg::ADDR_W-1:0] f_addr_o,
   output logic [iob_bus_pkg::N_FOLLOWERS*iob_bus_pkg::DATA_W-1:0] f_wdata_o,
   output logic [iob_bus_pkg::N_FOLLOWERS*iob_bus_pkg::STRB_W-1:0] f_wstrb_o,
   input  logic [iob_bus_pkg::N_FOLLOWERS*iob_bus_pkg::DATA_W-1:0] f_rdata_i,
   input  logic [iob_bus_pkg::N_FOLLOWERS-1:0]                 f_rvalid_i,
   input  logic [iob_bus_pkg::N_FOLLOWERS-1:0]                 f_ready_i,

   // Live follower selection for the current request
   input  logic [iob_bus_pkg::SEL_W-1:0]                       f_sel_i
);

   import iob_bus_pkg::*;

   // Selection of the last presented request, steers the response
   logic [SEL_W-1:0] sel_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sel_q <= '0;
      end else if (m_avalid_i) begin
         sel_q <= f_sel_i;
      end
   end

   // Request path

   // Avalid reaches only the addressed follower, in the same cycle
   always_comb begin
      f_avalid_o = '0;
      f_avalid_o[f_sel_i] = m_avalid_i;
   end

   // Payload is shared; followers ignore it without avalid
   assign f_addr_o  = {N_FOLLOWERS{m_addr_i}};
   assign f_wdata_o = {N_FOLLOWERS{m_wdata_i}};
   assign f_wstrb_o = {N_FOLLOWERS{m_wstrb_i}};

   // Response path

   // Ready follows the follower being addressed right now
   assign m_ready_o = f_ready_i[f_sel_i];

   // Rvalid and rdata belong to the request accepted a cycle ago
   assign m_rvalid_o = f_rvalid_i[sel_q];
   assign m_rdata_o  = f_rdata_i[sel_q*DATA_W +: DATA_W];

   // At most one follower sees a request
   a_avalid_onehot: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(f_avalid_o)
   ) else $error("split: more than one follower avalid");

endmodule

//--- logic/iob_sram.sv
module iob_sram (
   input  logic                             clk_i,
   input  logic                             rst_n_i,

   input  logic                             avalid_i,
   input  logic [iob_bus_pkg::ADDR_W-1:0]   addr_i,
   input  logic [iob_bus_pkg::DATA_W-1:0]   wdata_i,
   input  logic [iob_bus_pkg::STRB_W-1:0]   wstrb_i,
   output logic [iob_bus_pkg::DATA_W-1:0]   rdata_o,
   output logic                             rvalid_o,
   output logic                             ready_o
);

   import iob_bus_pkg::*;
   import iob_map_pkg::*;

   localparam int IDX_W = $clog2(SRAM_WORDS);

   bus_addr_u        addr_u;
   logic [IDX_W-1:0] idx;
   logic             acc;
   logic             is_wr;

   logic [DATA_W-1:0] mem [SRAM_WORDS];
   logic [DATA_W-1:0] rdata_q;
   logic              rvalid_q;

   // Word index sits above the byte lanes of the offset
   assign addr_u.raw = addr_i;
   assign idx        = addr_u.fields.offset[IDX_W+1:2];

   // Always ready, so every avalid is an accepted request
   assign ready_o = 1'b1;
   assign acc     = avalid_i && ready_o;
   assign is_wr   = |wstrb_i;

   // Byte-lane writes and the read word
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < STRB_W; b++) begin
         if (acc && wstrb_i[b]) begin
            mem[idx][b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
         end
      end
      if (acc) begin
         // Writes answer with zero data
         rdata_q <= is_wr ? '0 : mem[idx];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= acc;
      end
   end

   assign rdata_o  = rdata_q;
   assign rvalid_o = rvalid_q;

   // Each rvalid answers a request accepted the cycle before
   a_rvalid_has_req: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      rvalid_o |-> $past(acc)
   ) else $error("sram: rvalid without a request");

endmodule

//--- logic/iob_subsys_top.sv
module iob_subsys_top (
   input  logic                             clk_i,
   input  logic                             rst_n_i,

   // Master port
   input  logic                             avalid_i,
   input  logic [iob_bus_pkg::ADDR_W-1:0]   addr_i,
   input  logic [iob_bus_pkg::DATA_W-1:0]   wdata_i,
   input  logic [iob_bus_pkg::STRB_W-1:0]   wstrb_i,
   output logic [iob_bus_pkg::DATA_W-1:0]   rdata_o,
   output logic                             rvalid_o,
   output logic                             ready_o,

   // GPIO pins
   input  logic [iob_bus_pkg::DATA_W-1:0]   gpio_i,
   output logic [iob_bus_pkg::DATA_W-1:0]   gpio_o
);

   import iob_bus_pkg::*;
   import iob_map_pkg::*;

   bus_addr_u                       addr_u;
   logic [REGION_W-1:0]             region_mod;
   logic [SEL_W-1:0]                f_sel;

   logic [N_FOLLOWERS-1:0]          f_avalid;
   logic [N_FOLLOWERS*ADDR_W-1:0]   f_addr;
   logic [N_FOLLOWERS*DATA_W-1:0]   f_wdata;
   logic [N_FOLLOWERS*STRB_W-1:0]   f_wstrb;
   logic [N_FOLLOWERS*DATA_W-1:0]   f_rdata;
   logic [N_FOLLOWERS-1:0]          f_rvalid;
   logic [N_FOLLOWERS-1:0]          f_ready;

   // Regions past the last follower wrap around
   assign addr_u.raw = addr_i;
   assign region_mod = addr_u.fields.region % REGION_W'(N_FOLLOWERS);
   assign f_sel      = region_mod[SEL_W-1:0];

   iob_split u_split (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .m_avalid_i (avalid_i),
      .m_addr_i   (addr_i),
      .m_wdata_i  (wdata_i),
      .m_wstrb_i  (wstrb_i),
      .m_rdata_o  (rdata_o),
      .m_rvalid_o (rvalid_o),
      .m_ready_o  (ready_o),
      .f_avalid_o (f_avalid),
      .f_addr_o   (f_addr),
      .f_wdata_o  (f_wdata),
      .f_wstrb_o  (f_wstrb),
      .f_rdata_i  (f_rdata),
      .f_rvalid_i (f_rvalid),
      .f_ready_i  (f_ready),
      .f_sel_i    (f_sel)
   );

   iob_sram u_sram (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .avalid_i (f_avalid[REGION_SRAM]),
      .addr_i   (f_addr[REGION_SRAM*ADDR_W +: ADDR_W]),
      .wdata_i  (f_wdata[REGION_SRAM*DATA_W +: DATA_W]),
      .wstrb_i  (f_wstrb[REGION_SRAM*STRB_W +: STRB_W]),
      .rdata_o  (f_rdata[REGION_SRAM*DATA_W +: DATA_W]),
      .rvalid_o (f_rvalid[REGION_SRAM]),
      .ready_o  (f_ready[REGION_SRAM])
   );

   iob_gpio_regs u_gpio (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .avalid_i (f_avalid[REGION_GPIO]),
      .addr_i   (f_addr[REGION_GPIO*ADDR_W +: ADDR_W]),
      .wdata_i  (f_wdata[REGION_GPIO*DATA_W +: DATA_W]),
      .wstrb_i  (f_wstrb[REGION_GPIO*STRB_W +: STRB_W]),
      .rdata_o  (f_rdata[REGION_GPIO*DATA_W +: DATA_W]),
      .rvalid_o (f_rvalid[REGION_GPIO]),
      .ready_o  (f_ready[REGION_GPIO]),
      .gpio_i   (gpio_i),
      .gpio_o   (gpio_o)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f verilog.f \
   --top-module tb_iob_subsys -Mdir obj_dir

out=$(./obj_dir/Vtb_iob_subsys)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "Simulation PASSED"

//--- sim/iob_subsys_checker.sv
module iob_subsys_checker #(
   parameter int NAME_W = 128
) (
   input  logic                             clk_i,
   input  logic                             rst_n_i,

   // Master port as seen by the DUT
   input  logic                             avalid_i,
   input  logic                             ready_i,
   input  logic                             rvalid_i,
   input  logic [iob_bus_pkg::DATA_W-1:0]   rdata_i,
   input  logic [iob_bus_pkg::DATA_W-1:0]   gpio_i,

   // Expected response of the request now on the bus
   input  logic [NAME_W-1:0]                name_i,
   input  logic [iob_bus_pkg::DATA_W-1:0]   exp_rdata_i,
   input  logic                             chk_gpio_i,
   input  logic [iob_bus_pkg::DATA_W-1:0]   exp_gpio_i,
   input  int                               exp_wait_i,

   output int                               n_tests_o,
   output int                               n_errors_o
);

   timeunit 1ns;
   timeprecision 1ps;

   import iob_bus_pkg::*;

   typedef struct packed {
      logic [NAME_W-1:0] name;
      logic [DATA_W-1:0] exp_rdata;
      logic              chk_gpio;
      logic [DATA_W-1:0] exp_gpio;
      int                exp_wait;
      int                act_wait;
   } pend_t;

   // Requests accepted and still waiting for their rvalid
   pend_t pend_q[$];
   pend_t item;

   // Cycles the request on the bus has spent with ready low
   int    wait_cnt;

   task automatic compare_response(input pend_t p);
      logic ok;
      ok = 1'b1;
      n_tests_o = n_tests_o + 1;
      if (rdata_i !== p.exp_rdata) begin
         $display("FAIL %s: rdata expected 0x%08h actual 0x%08h", p.name, p.exp_rdata, rdata_i);
         ok = 1'b0;
      end
      if (p.chk_gpio && (gpio_i !== p.exp_gpio)) begin
         $display("FAIL %s: gpio_o expected 0x%08h actual 0x%08h", p.name, p.exp_gpio, gpio_i);
         ok = 1'b0;
      end
      if (p.act_wait != p.exp_wait) begin
         $display("FAIL %s: wait cycles expected %0d actual %0d", p.name, p.exp_wait,
                  p.act_wait);
         ok = 1'b0;
      end
      if (ok) begin
         $display("PASS %s", p.name);
      end else begin
         n_errors_o = n_errors_o + 1;
      end
   endtask

   // Sampled at the falling edge, away from the driving edge
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         pend_q.delete();
         wait_cnt = 0;
      end else begin
         // Every accepted request must answer exactly one cycle later
         if (rvalid_i) begin
            if (pend_q.size() == 0) begin
               $display("ERROR: rvalid arrived with no request outstanding");
               n_errors_o = n_errors_o + 1;
            end else begin
               item = pend_q.pop_front();
               compare_response(item);
            end
         end else if (pend_q.size() != 0) begin
            item = pend_q.pop_front();
            $display("ERROR: test %s was accepted but never got an rvalid", item.name);
            n_tests_o  = n_tests_o + 1;
            n_errors_o = n_errors_o + 1;
         end
         if (avalid_i && !ready_i) begin
            wait_cnt = wait_cnt + 1;
         end
         // Both high here means acceptance at the next rising edge
         if (avalid_i && ready_i) begin
            item.name      = name_i;
            item.exp_rdata = exp_rdata_i;
            item.chk_gpio  = chk_gpio_i;
            item.exp_gpio  = exp_gpio_i;
            item.exp_wait  = exp_wait_i;
            item.act_wait  = wait_cnt;
            wait_cnt       = 0;
            pend_q.push_back(item);
         end
      end
   end

endmodule

//--- sim/tb_iob_subsys.sv
module tb_iob_subsys;

   timeunit 1ns;
   timeprecision 1ps;

   import iob_bus_pkg::*;
   import iob_map_pkg::*;

   localparam int NAME_W = 16 * 8;

   typedef struct packed {
      logic [NAME_W-1:0] name;
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] strb;
      logic [DATA_W-1:0] exp_rdata;
      logic              chk_gpio;
      logic [DATA_W-1:0] exp_gpio;
      int                exp_wait;
   } entry_t;

   logic              clk_i;
   logic              rst_n_i;
   logic              avalid;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic [DATA_W-1:0] rdata;
   logic              rvalid;
   logic              ready;
   logic [DATA_W-1:0] gpio_in;
   logic [DATA_W-1:0] gpio_out;

   logic [NAME_W-1:0] cur_name;
   logic [DATA_W-1:0] cur_exp_rdata;
   logic              cur_chk_gpio;
   logic [DATA_W-1:0] cur_exp_gpio;
   int                cur_exp_wait;

   entry_t            stim_q[$];
   entry_t            cur;
   int                n_entries;
   int                n_tests;
   int                n_errors;
   logic [DATA_W-1:0] d0, d1, d2, d3, d4, gpio_in_val;

   iob_subsys_top uut (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .avalid_i (avalid),
      .addr_i   (addr),
      .wdata_i  (wdata),
      .wstrb_i  (wstrb),
      .rdata_o  (rdata),
      .rvalid_o (rvalid),
      .ready_o  (ready),
      .gpio_i   (gpio_in),
      .gpio_o   (gpio_out)
   );

   iob_subsys_checker #(.NAME_W(NAME_W)) u_checker (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .avalid_i    (avalid),
      .ready_i     (ready),
      .rvalid_i    (rvalid),
      .rdata_i     (rdata),
      .gpio_i      (gpio_out),
      .name_i      (cur_name),
      .exp_rdata_i (cur_exp_rdata),
      .chk_gpio_i  (cur_chk_gpio),
      .exp_gpio_i  (cur_exp_gpio),
      .exp_wait_i  (cur_exp_wait),
      .n_tests_o   (n_tests),
      .n_errors_o  (n_errors)
   );

   always #10 clk_i = ~clk_i;

   function automatic logic [ADDR_W-1:0] word_addr(input int region, input int idx);
      return {REGION_W'(region), OFFSET_W'(idx * 4)};
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input logic [OFFSET_W-1:0] offset);
      return {REGION_W'(REGION_GPIO), offset};
   endfunction

   // Region wraps modulo the follower count
   function automatic logic is_gpio(input logic [ADDR_W-1:0] a);
      return (int'(a[ADDR_W-1 -: REGION_W]) % N_FOLLOWERS) == REGION_GPIO;
   endfunction

   // Strobed bytes come from the new word, the rest keep the old one
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            res[b*BYTE_W +: BYTE_W] = new_w[b*BYTE_W +: BYTE_W];
         end
      end
      return res;
   endfunction

   task automatic add_entry(input logic [NAME_W-1:0] name, input logic wr,
                            input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                            input logic [STRB_W-1:0] s, input logic [DATA_W-1:0] exp_rd,
                            input logic chk, input logic [DATA_W-1:0] exp_gp);
      entry_t e;
      entry_t prev;
      e = '{name, wr, a, d, s, exp_rd, chk, exp_gp, 0};
      // A GPIO request right after a GPIO write waits out the settle cycle
      if (stim_q.size() != 0) begin
         prev = stim_q[$];
         if (prev.wr && is_gpio(prev.addr) && is_gpio(a)) begin
            e.exp_wait = 1;
         end
      end
      stim_q.push_back(e);
   endtask

   // Writes always answer with zero data
   task automatic build_table();
      add_entry("sram_wr_3", 1'b1, word_addr(REGION_SRAM, 3), d0, 4'hF, '0, 1'b0, '0);
      add_entry("sram_wr_17", 1'b1, word_addr(REGION_SRAM, 17), d1, 4'hF, '0, 1'b0, '0);
      add_entry("sram_wr_42", 1'b1, word_addr(REGION_SRAM, 42), d2, 4'hF, '0, 1'b0, '0);
      add_entry("sram_rd_3", 1'b0, word_addr(REGION_SRAM, 3), '0, '0, d0, 1'b0, '0);
      add_entry("sram_rd_42", 1'b0, word_addr(REGION_SRAM, 42), '0, '0, d2, 1'b0, '0);
      add_entry("sram_rd_17", 1'b0, word_addr(REGION_SRAM, 17), '0, '0, d1, 1'b0, '0);
      add_entry("sram_wr_5", 1'b1, word_addr(REGION_SRAM, 5), d3, 4'hF, '0, 1'b0, '0);
      add_entry("sram_strb_5", 1'b1, word_addr(REGION_SRAM, 5), d4, 4'b0101, '0, 1'b0, '0);
      add_entry("sram_rd_5", 1'b0, word_addr(REGION_SRAM, 5), '0, '0,
                merge_bytes(d3, d4, 4'b0101), 1'b0, '0);
      // Region 2 wraps onto the SRAM
      add_entry("wrap_rd_3", 1'b0, word_addr(2, 3), '0, '0, d0, 1'b0, '0);
      // Write then read of the GPIO block waits out the settle cycle
      add_entry("scr_wr", 1'b1, reg_addr(REG_SCRATCH), 32'hC0DE_1234, 4'hF, '0, 1'b0, '0);
      add_entry("scr_rd", 1'b0, reg_addr(REG_SCRATCH), '0, '0, 32'hC0DE_1234, 1'b0, '0);
      add_entry("unmap_wr", 1'b1, reg_addr(OFFSET_W'('h10)), '1, 4'hF, '0, 1'b0, '0);
      add_entry("unmap_rd", 1'b0, reg_addr(OFFSET_W'('h10)), '0, '0, '0, 1'b0, '0);
      add_entry("gpo_wr", 1'b1, reg_addr(REG_GPIO_OUT), 32'hA5A5_0F0F, 4'hF, '0,
                1'b1, 32'hA5A5_0F0F);
      add_entry("gpi_rd", 1'b0, reg_addr(REG_GPIO_IN), '0, '0, gpio_in_val, 1'b0, '0);
      // Alternating followers on back-to-back requests
      add_entry("alt_gpo_wr", 1'b1, reg_addr(REG_GPIO_OUT), 32'h1357_9BDF, 4'b0011, '0,
                1'b1, merge_bytes(32'hA5A5_0F0F, 32'h1357_9BDF, 4'b0011));
      add_entry("alt_sram_rd", 1'b0, word_addr(REGION_SRAM, 17), '0, '0, d1, 1'b0, '0);
      add_entry("alt_scr_rd", 1'b0, reg_addr(REG_SCRATCH), '0, '0, 32'hC0DE_1234, 1'b0, '0);
      add_entry("alt_sram_wr", 1'b1, word_addr(REGION_SRAM, 63), d2, 4'hF, '0, 1'b0, '0);
      add_entry("alt_gpo_rd", 1'b0, reg_addr(REG_GPIO_OUT), '0, '0,
                merge_bytes(32'hA5A5_0F0F, 32'h1357_9BDF, 4'b0011), 1'b0, '0);
      add_entry("alt_sram_rd_63", 1'b0, word_addr(REGION_SRAM, 63), '0, '0, d2, 1'b0, '0);
   endtask

   initial begin
      void'($urandom(19));
      d0          = $urandom();
      d1          = $urandom();
      d2          = $urandom();
      d3          = $urandom();
      d4          = $urandom();
      gpio_in_val = $urandom();
      build_table();

      clk_i         = 1'b0;
      rst_n_i       <= 1'b0;
      avalid        <= 1'b0;
      addr          <= '0;
      wdata         <= '0;
      wstrb         <= '0;
      gpio_in       <= gpio_in_val;
      cur_name      <= '0;
      cur_exp_rdata <= '0;
      cur_chk_gpio  <= 1'b0;
      cur_exp_gpio  <= '0;
      cur_exp_wait  <= 0;
      n_entries     = stim_q.size();

      repeat (3) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);

      for (int i = 0; i < stim_q.size(); i++) begin
         cur = stim_q[i];
         avalid        <= 1'b1;
         addr          <= cur.addr;
         wdata         <= cur.wdata;
         wstrb         <= cur.wr ? cur.strb : '0;
         cur_name      <= cur.name;
         cur_exp_rdata <= cur.exp_rdata;
         cur_chk_gpio  <= cur.chk_gpio;
         cur_exp_gpio  <= cur.exp_gpio;
         cur_exp_wait  <= cur.exp_wait;
         // Hold the request until the addressed follower is ready
         @(negedge clk_i);
         while (!ready) begin
            @(negedge clk_i);
         end
         @(posedge clk_i);
      end
      avalid <= 1'b0;
      wstrb  <= '0;

      // Room for the last response and for any stray rvalid
      repeat (4) @(negedge clk_i);
      $display("Tests: %0d run of %0d, %0d failed", n_tests, n_entries, n_errors);
      if (n_errors == 0 && n_tests == n_entries) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Each request gets 10 cycles on top of reset
   initial begin
      wait (n_entries != 0);
      repeat (n_entries * 10 + 3) @(posedge clk_i);
      $display("Timeout: the requests did not complete in %0d cycles", n_entries * 10 + 3);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- verilog.f
logic/iob_bus_pkg.sv
logic/iob_map_pkg.sv
logic/iob_split.sv
logic/iob_sram.sv
logic/iob_gpio_regs.sv
logic/iob_subsys_top.sv
sim/iob_subsys_checker.sv
sim/tb_iob_subsys.sv
